/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --timescale 1ns/1ps -j 0
TOP      := tb_exu_ctrl
FILELIST := all.f
BUILD    := obj_dir
LOG      := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(SIM), run $(TOP), check $(LOG)"
	@echo "  clean  remove build directory and log"
	@echo "  help   this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "^sim passed$$" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

/* all.f */
common/exu_pkg.sv
hdl/bjp_decode.sv
exu/exu_bru.sv
hdl/exu_commit.sv
hdl/exu_ctrl_top.sv
dv/tb_exu_ctrl.sv

/* common/exu_pkg.sv */
// ##############################
// widths, rv32 opcodes and funct3 codes
// structs for the branch/jump execute path
// ##############################
`default_nettype none

package exu_pkg;

    localparam int XLEN            = 32;  // one word
    localparam int INST_ADDR_WIDTH = 32;  // byte address of an instruction
    localparam int REG_ADDR_WIDTH  = 5;   // x0..x31

    // major opcodes, inst[6:0]
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_FENCE  = 7'b0001111;  // misc-mem, fence and fence.i

    // branch funct3, inst[14:12]
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // one-hot operation flags, all zero for anything else
    typedef struct packed {
        logic jal;
        logic jalr;
        logic beq;
        logic bne;
        logic blt;
        logic bge;
        logic bltu;
        logic bgeu;
        logic fence;
    } bjp_op_t;

    // decoded request as seen by the resolution unit
    typedef struct packed {
        logic                        valid;       // instruction slot occupied
        logic [INST_ADDR_WIDTH-1:0]  pc;
        bjp_op_t                     op;
        logic [XLEN-1:0]             op1;         // rs1 for compares
        logic [XLEN-1:0]             op2;         // rs2 for compares
        logic [XLEN-1:0]             jump_op1;    // pc, or rs1 for jalr
        logic [XLEN-1:0]             jump_op2;    // sign-extended imm, or 4
        logic                        pred_taken;  // btfn guess of the front end
        logic [REG_ADDR_WIDTH-1:0]   rd;
        logic                        int_assert;  // independent of valid
        logic [INST_ADDR_WIDTH-1:0]  int_addr;
    } bjp_req_t;

    // fetch redirect
    typedef struct packed {
        logic                        valid;
        logic [INST_ADDR_WIDTH-1:0]  target;
    } redirect_t;

    // misaligned fetch trap report
    typedef struct packed {
        logic                        valid;
        logic [INST_ADDR_WIDTH-1:0]  pc;    // faulting jump/branch
        logic [INST_ADDR_WIDTH-1:0]  tval;  // bad target
    } trap_t;

    // link write-back for jal/jalr
    typedef struct packed {
        logic                        valid;
        logic [REG_ADDR_WIDTH-1:0]   rd;
        logic [XLEN-1:0]             data;  // pc+4
    } link_t;

endpackage

`default_nettype wire

/* dv/tb_exu_ctrl.sv */
// ##############################
// directed testbench for exu_ctrl_top
// reference model, compare tasks, timeout
// ##############################
`timescale 1ns/1ps
`default_nettype none

module tb_exu_ctrl;
    import exu_pkg::*;

    localparam int RST_CYCLES = 4;
    localparam int N_BR  = 8;    // per branch type and direction
    localparam int N_JMP = 8;
    localparam int N_MIS = 4;
    localparam int N_IRQ = 4;
    localparam int N_MIX = 200;  // back-to-back stream
    // every test drains with 3 idles plus up to 3 wait cycles
    localparam int ISSUED = 24 * N_BR + 4 * N_JMP + 4 + 6 * N_MIS + 8 * N_IRQ + N_MIX
                          + 6 * 6 + RST_CYCLES + 1;
    localparam int TIMEOUT_CYCLES = 2 * ISSUED + 100;
    localparam logic [17:0] BR_F3S = {F3_BGEU, F3_BLTU, F3_BGE, F3_BLT, F3_BNE, F3_BEQ};

    // item kinds, idle is an empty slot
    localparam logic [2:0] K_IDLE = 3'd0;
    localparam logic [2:0] K_BR = 3'd1;
    localparam logic [2:0] K_JAL = 3'd2;
    localparam logic [2:0] K_JALR = 3'd3;
    localparam logic [2:0] K_FENCE = 3'd4;
    localparam logic [2:0] K_OTHER = 3'd5;  // plain add, not a bjp op

    typedef struct packed {
        logic        vld;
        logic [2:0]  kind;
        logic [2:0]  f3;
        logic [31:0] imm;   // sign-extended byte offset
        logic [4:0]  rd;
        logic [31:0] pc;
        logic [31:0] rs1;
        logic [31:0] rs2;
        logic        intr;
        logic [31:0] iaddr;
    } item_t;

    typedef struct packed {
        redirect_t   redirect;
        trap_t       trap;
        link_t       link;
        logic [31:0] due;  // cycle the outputs belong to
    } exp_t;

    logic        clk = 1'b0;
    logic        arst_n;
    logic        valid;
    logic [31:0] pc;
    logic [31:0] inst;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    logic        int_assert;
    logic [31:0] int_addr;
    redirect_t   redirect;
    trap_t       trap;
    link_t       link;

    int          cyc = 0;
    int          checks = 0;
    int          errors = 0;
    logic        squash_m = 1'b0;  // model copy of the wrong-path flag
    logic [31:0] rng = 32'd88;
    exp_t        expq[$];
    exp_t        mon_exp;

    exu_ctrl_top dut (
        .clk_i        (clk),
        .arst_n_i     (arst_n),
        .valid_i      (valid),
        .pc_i         (pc),
        .inst_i       (inst),
        .rs1_data_i   (rs1_data),
        .rs2_data_i   (rs2_data),
        .int_assert_i (int_assert),
        .int_addr_i   (int_addr),
        .redirect_o   (redirect),
        .trap_o       (trap),
        .link_o       (link)
    );

    always #4 clk = ~clk;  // 8 ns period

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("sim failed");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function logic [31:0] rand32();
        rng = xorshift32(rng);  // advances the shared state
        return rng;
    endfunction

    // rv32i encodings, register fields other than rd carry no meaning here
    function automatic logic [31:0] encode(input item_t it);
        case (it.kind)
            K_BR: return {it.imm[12], it.imm[10:5], 5'd2, 5'd1, it.f3, it.imm[4:1],
                          it.imm[11], OPC_BRANCH};
            K_JAL: return {it.imm[20], it.imm[10:1], it.imm[11], it.imm[19:12], it.rd,
                           OPC_JAL};
            K_JALR: return {it.imm[11:0], 5'd1, 3'b000, it.rd, OPC_JALR};
            K_FENCE: return 32'h0ff0000f;  // fence iorw,iorw
            K_OTHER: return {7'b0, 5'd2, 5'd1, 3'b000, it.rd, 7'b0110011};
            default: return 32'h00000013;  // nop
        endcase
    endfunction

    // expected outputs for one slot, squash is the state before it
    function automatic exp_t model(input item_t it, input logic squash);
        exp_t        e;
        logic        br;
        logic        jal;
        logic        jalr;
        logic        fence;
        logic        cond;
        logic        taken;
        logic        pred;
        logic        rollback;
        logic        jump;
        logic        mis;
        logic [31:0] tgt;
        br    = it.vld && it.kind == K_BR;
        jal   = it.vld && it.kind == K_JAL;
        jalr  = it.vld && it.kind == K_JALR;
        fence = it.vld && it.kind == K_FENCE;
        case (it.f3)
            F3_BEQ:  cond = it.rs1 == it.rs2;
            F3_BNE:  cond = it.rs1 != it.rs2;
            F3_BLT:  cond = $signed(it.rs1) < $signed(it.rs2);
            F3_BGE:  cond = $signed(it.rs1) >= $signed(it.rs2);
            F3_BLTU: cond = it.rs1 < it.rs2;
            default: cond = it.rs1 >= it.rs2;
        endcase
        taken    = (br && cond) || jalr;
        pred     = br && it.imm[31];  // backward means guessed taken
        rollback = pred && !taken;
        jump     = it.intr || fence || rollback || (taken && !pred);
        if (it.intr)
            tgt = it.iaddr;
        else if (jalr)
            tgt = (it.rs1 + it.imm) & ~32'd1;
        else if (fence || rollback)
            tgt = it.pc + 32'd4;
        else
            tgt = it.pc + it.imm;
        mis = (tgt[1:0] != 2'b00) && (jump || jal);
        e = '0;
        e.redirect.valid  = jump && !mis && !squash;
        e.redirect.target = tgt;
        e.trap.valid = mis && !squash;
        e.trap.pc    = it.pc;
        e.trap.tval  = tgt;
        // interrupt takes the slot, so no link either
        e.link.valid = (jal || jalr) && it.rd != 5'd0 && !mis && !it.intr && !squash;
        e.link.rd    = it.rd;
        e.link.data  = it.pc + 32'd4;
        return e;
    endfunction

    function automatic item_t idle_item();
        item_t it;
        it = '0;
        it.kind = K_IDLE;
        return it;
    endfunction

    function automatic item_t base_item(input logic [2:0] kind);
        item_t it;
        it = '0;
        it.vld  = 1'b1;
        it.kind = kind;
        it.pc   = rand32() & ~32'd3;  // aligned pc
        it.rs1  = rand32();
        it.rs2  = rand32();
        it.rd   = 5'd1;
        return it;
    endfunction

    function automatic item_t rand_branch(input logic [2:0] f3, input logic back);
        item_t       it;
        logic [31:0] r;
        it = base_item(K_BR);
        r = rand32();
        it.f3  = f3;
        it.imm = {22'b0, r[7:0], 2'b00} + 32'd4;  // 4..1024
        if (back)
            it.imm = -it.imm;
        if (r[8])
            it.rs2 = it.rs1;  // equal operands now and then
        return it;
    endfunction

    function automatic item_t mis_branch();
        item_t it;
        it = rand_branch(F3_BEQ, 1'b0);
        it.rs2    = it.rs1;  // always taken
        it.imm[1] = 1'b1;    // target 2 mod 4
        return it;
    endfunction

    // jal or jalr, target 2 mod 4 when mis is set
    function automatic item_t rand_jump(input logic [2:0] kind, input logic mis);
        item_t       it;
        logic [31:0] r;
        it = base_item(kind);
        r = rand32();
        it.rd  = (r[4:0] == 5'd0) ? 5'd1 : r[4:0];
        it.rs1 = {it.rs1[31:2], 2'b00};
        if (kind == K_JALR)
            it.imm = {{21{r[16]}}, r[16:8], mis, r[5]};  // bit 0 gets cleared
        else
            it.imm = {{12{r[27]}}, r[27:10], mis, 1'b0};
        return it;
    endfunction

    function automatic logic [2:0] pick_f3(input logic [31:0] r);
        logic [31:0] m;
        m = r % 32'd6;
        return BR_F3S[m * 3 +: 3];
    endfunction

    // drive one slot just after the edge and queue what it should produce
    task automatic issue(input item_t it);
        exp_t e;
        @(posedge clk);
        #1;
        valid      = it.vld;
        pc         = it.pc;
        inst       = encode(it);
        rs1_data   = it.rs1;
        rs2_data   = it.rs2;
        int_assert = it.intr;
        int_addr   = it.iaddr;
        e = model(it, squash_m);
        squash_m = e.redirect.valid | e.trap.valid;
        e.due = cyc + 2;  // fixed two-cycle latency
        expq.push_back(e);
    endtask

    task automatic check_redirect(input redirect_t got, input redirect_t want);
        checks++;
        if (got.valid !== want.valid || (want.valid && got.target !== want.target)) begin
            errors++;
            $display("[ERROR] %0t redirect: got %0b/%h, expected %0b/%h", $time,
                     got.valid, got.target, want.valid, want.target);
        end
    endtask

    task automatic check_trap(input trap_t got, input trap_t want);
        checks++;
        if (got.valid !== want.valid ||
            (want.valid && (got.pc !== want.pc || got.tval !== want.tval))) begin
            errors++;
            $display("[ERROR] %0t trap: got %0b pc %h tval %h, expected %0b pc %h tval %h",
                     $time, got.valid, got.pc, got.tval, want.valid, want.pc, want.tval);
        end
    endtask

    task automatic check_link(input link_t got, input link_t want);
        checks++;
        if (got.valid !== want.valid ||
            (want.valid && (got.rd !== want.rd || got.data !== want.data))) begin
            errors++;
            $display("[ERROR] %0t link: got %0b x%0d=%h, expected %0b x%0d=%h", $time,
                     got.valid, got.rd, got.data, want.valid, want.rd, want.data);
        end
    endtask

    // mid-cycle compare, any output without an expectation is an error
    always @(negedge clk) begin
        if (expq.size() != 0 && expq[0].due == cyc) begin
            mon_exp = expq.pop_front();
            check_redirect(redirect, mon_exp.redirect);
            check_trap(trap, mon_exp.trap);
            check_link(link, mon_exp.link);
        end else if (redirect.valid || trap.valid || link.valid) begin
            errors++;
            $display("[ERROR] %0t output valid with no instruction due", $time);
        end
    end

    task automatic finish_test(input string name, input int err0);
        repeat (3) issue(idle_item());
        while (expq.size() != 0)
            @(negedge clk);
        $display("test %s: %0d errors", name, errors - err0);
    endtask

    task automatic run_branches(input string name, input logic back);
        int err0;
        int f;
        int n;
        err0 = errors;
        for (f = 0; f < 6; f++) begin
            for (n = 0; n < N_BR; n++) begin
                issue(rand_branch(BR_F3S[f * 3 +: 3], back));
                issue(idle_item());  // keeps the next slot out of squash
            end
        end
        finish_test(name, err0);
    endtask

    task automatic run_jumps();
        int    err0;
        int    n;
        item_t it;
        err0 = errors;
        for (n = 0; n < N_JMP; n++) begin
            issue(rand_jump(K_JALR, 1'b0));
            issue(idle_item());
            issue(rand_jump(K_JAL, 1'b0));
            issue(idle_item());
        end
        it = rand_jump(K_JALR, 1'b0);
        it.rd = 5'd0;  // x0, no write-back
        issue(it);
        issue(idle_item());
        it = rand_jump(K_JAL, 1'b0);
        it.rd = 5'd0;
        issue(it);
        issue(idle_item());
        finish_test("jumps", err0);
    endtask

    task automatic run_misaligned();
        int err0;
        int n;
        err0 = errors;
        for (n = 0; n < N_MIS; n++) begin
            issue(rand_jump(K_JALR, 1'b1));
            issue(idle_item());
            issue(rand_jump(K_JAL, 1'b1));
            issue(idle_item());
            issue(mis_branch());
            issue(idle_item());
        end
        finish_test("misaligned", err0);
    endtask

    task automatic run_fence_irq();
        int    err0;
        int    n;
        item_t it;
        err0 = errors;
        for (n = 0; n < N_IRQ; n++) begin
            issue(base_item(K_FENCE));
            issue(idle_item());
            it = rand_branch(pick_f3(rand32()), rng[0]);
            it.intr  = 1'b1;
            it.iaddr = rand32() & ~32'd3;
            issue(it);
            issue(idle_item());
            it = base_item(K_OTHER);
            it.intr  = 1'b1;
            it.iaddr = rand32() & ~32'd3;
            issue(it);
            issue(idle_item());
            it = idle_item();  // interrupt in an empty slot
            it.intr  = 1'b1;
            it.iaddr = rand32() & ~32'd3;
            issue(it);
            issue(idle_item());
        end
        finish_test("fence_irq", err0);
    endtask

    task automatic run_stream();
        int          err0;
        int          n;
        logic [31:0] r;
        item_t       it;
        err0 = errors;
        for (n = 0; n < N_MIX; n++) begin
            r = rand32();
            case (r[2:0])
                3'd0, 3'd1: it = rand_branch(pick_f3(r >> 4), r[3]);
                3'd2: it = rand_jump(K_JAL, r[7] & r[8]);
                3'd3: it = rand_jump(K_JALR, r[7] & r[8]);
                3'd4: it = base_item(K_FENCE);
                3'd5: it = base_item(K_OTHER);
                3'd6: it = mis_branch();
                default: it = idle_item();
            endcase
            if (r[12:9] == 4'd0) begin
                it.intr  = 1'b1;  // about one in 16
                it.iaddr = rand32() & ~32'd3;
            end
            issue(it);
        end
        finish_test("stream", err0);
    endtask

    initial begin
        arst_n     = 1'b0;
        valid      = 1'b0;
        pc         = '0;
        inst       = 32'h00000013;
        rs1_data   = '0;
        rs2_data   = '0;
        int_assert = 1'b0;
        int_addr   = '0;
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        arst_n = 1'b1;
        run_branches("forward", 1'b0);
        run_branches("backward", 1'b1);
        run_jumps();
        run_misaligned();
        run_fence_irq();
        run_stream();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* exu/exu_bru.sv */
// ##############################
// combinational branch/jump resolution
// ##############################
`timescale 1ns/1ps
`default_nettype none

module exu_bru (
    input  wire exu_pkg::bjp_req_t              req_i,
    output logic                                jump_flag_o,
    output logic [exu_pkg::INST_ADDR_WIDTH-1:0] jump_addr_o,
    output logic                                misaligned_fetch_o
);
    import exu_pkg::*;

    logic            op1_eq_op2;
    logic            op1_ge_op2_signed;
    logic            op1_ge_op2_unsigned;
    logic            branch_cond;    // taken condition, jalr counts as taken
    logic            pred_rollback;  // predicted taken, turned out not taken
    logic            jump_flag;
    logic [XLEN-1:0] adder_op2;
    logic [XLEN-1:0] adder_result;
    logic [XLEN-1:0] jalr_target;

    // compares
    assign op1_eq_op2          = (req_i.op1 == req_i.op2);
    assign op1_ge_op2_signed   = $signed(req_i.op1) >= $signed(req_i.op2);
    assign op1_ge_op2_unsigned = req_i.op1 >= req_i.op2;

    assign branch_cond = req_i.valid & (
        (req_i.op.beq  &  op1_eq_op2)          |
        (req_i.op.bne  & ~op1_eq_op2)          |
        (req_i.op.blt  & ~op1_ge_op2_signed)   |
        (req_i.op.bge  &  op1_ge_op2_signed)   |
        (req_i.op.bltu & ~op1_ge_op2_unsigned) |
        (req_i.op.bgeu &  op1_ge_op2_unsigned) |
        req_i.op.jalr
    );

    assign pred_rollback = req_i.valid & req_i.pred_taken & ~branch_cond;

    // one adder, pc+imm normally, pc+4 on rollback
    assign adder_op2    = pred_rollback ? XLEN'(4) : req_i.jump_op2;
    assign adder_result = req_i.jump_op1 + adder_op2;
    assign jalr_target  = {adder_result[XLEN-1:1], 1'b0};  // bit 0 cleared

    // correctly predicted taken branch needs no redirect
    assign jump_flag = req_i.int_assert
                     | (branch_cond & ~req_i.pred_taken)
                     | (req_i.valid & req_i.op.fence)
                     | pred_rollback;

    // interrupt wins over the instruction's own target
    assign jump_addr_o = req_i.int_assert ? req_i.int_addr :
                         req_i.op.jalr    ? jalr_target    : adder_result;

    // jal is checked here though the front end already redirected it
    assign misaligned_fetch_o = (jump_addr_o[1:0] != 2'b00)
                              & (jump_flag | (req_i.valid & req_i.op.jal));

    assign jump_flag_o = jump_flag & ~misaligned_fetch_o;  // trap instead

endmodule

`default_nettype wire

/* hdl/bjp_decode.sv */
// ##############################
// registered decode of branch, jump and fence
// into op flags, operands and prediction bit
// ##############################
`timescale 1ns/1ps
`default_nettype none

module bjp_decode (
    input  wire                                clk_i,
    input  wire                                arst_n_i,
    input  wire                                valid_i,
    input  wire [exu_pkg::INST_ADDR_WIDTH-1:0] pc_i,
    input  wire [31:0]                         inst_i,
    input  wire [exu_pkg::XLEN-1:0]            rs1_data_i,
    input  wire [exu_pkg::XLEN-1:0]            rs2_data_i,
    input  wire                                int_assert_i,
    input  wire [exu_pkg::INST_ADDR_WIDTH-1:0] int_addr_i,
    output exu_pkg::bjp_req_t                  req_o
);
    import exu_pkg::*;

    logic [6:0]                 opcode;
    logic [2:0]                 funct3;
    logic [XLEN-1:0]            imm_b;
    logic [XLEN-1:0]            imm_i;
    logic [XLEN-1:0]            imm_j;
    bjp_op_t                    op_d;
    logic                       is_branch;
    logic [XLEN-1:0]            jump_op1_d;
    logic [XLEN-1:0]            jump_op2_d;
    logic                       pred_taken_d;

    // control flops, reset
    logic                       valid_q;
    bjp_op_t                    op_q;
    logic                       pred_taken_q;
    logic                       int_assert_q;
    // payload flops, no reset
    logic [INST_ADDR_WIDTH-1:0] pc_q;
    logic [XLEN-1:0]            op1_q;
    logic [XLEN-1:0]            op2_q;
    logic [XLEN-1:0]            jump_op1_q;
    logic [XLEN-1:0]            jump_op2_q;
    logic [REG_ADDR_WIDTH-1:0]  rd_q;
    logic [INST_ADDR_WIDTH-1:0] int_addr_q;

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];

    // immediates, all sign-extended from inst[31]
    assign imm_b = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
    assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_j = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

    always_comb begin
        op_d = '0;  // non-bjp instructions leave every flag low
        if (valid_i) begin
            case (opcode)
                OPC_BRANCH: begin
                    case (funct3)
                        F3_BEQ:  op_d.beq  = 1'b1;
                        F3_BNE:  op_d.bne  = 1'b1;
                        F3_BLT:  op_d.blt  = 1'b1;
                        F3_BGE:  op_d.bge  = 1'b1;
                        F3_BLTU: op_d.bltu = 1'b1;
                        F3_BGEU: op_d.bgeu = 1'b1;
                        default: ;  // 010/011 reserved
                    endcase
                end
                OPC_JAL:   op_d.jal   = 1'b1;
                OPC_JALR:  op_d.jalr  = (funct3 == 3'b000);
                OPC_FENCE: op_d.fence = 1'b1;
                default:   ;
            endcase
        end
    end

    assign is_branch = op_d.beq | op_d.bne | op_d.blt | op_d.bge | op_d.bltu | op_d.bgeu;

    // adder operands for the shared target adder
    assign jump_op1_d = op_d.jalr ? rs1_data_i : pc_i;
    assign jump_op2_d = op_d.fence ? XLEN'(4) :
                        op_d.jalr  ? imm_i    :
                        op_d.jal   ? imm_j    : imm_b;

    // backward branch was predicted taken by the front end
    assign pred_taken_d = is_branch & imm_b[XLEN-1];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q      <= 1'b0;
            op_q         <= '0;
            pred_taken_q <= 1'b0;
            int_assert_q <= 1'b0;
        end else begin
            valid_q      <= valid_i;
            op_q         <= op_d;
            pred_taken_q <= pred_taken_d;
            int_assert_q <= int_assert_i;  // taken even without valid_i
        end
    end

    always_ff @(posedge clk_i) begin
        pc_q       <= pc_i;
        op1_q      <= rs1_data_i;
        op2_q      <= rs2_data_i;
        jump_op1_q <= jump_op1_d;
        jump_op2_q <= jump_op2_d;
        rd_q       <= inst_i[11:7];
        int_addr_q <= int_addr_i;
    end

    always_comb begin
        req_o.valid      = valid_q;
        req_o.pc         = pc_q;
        req_o.op         = op_q;
        req_o.op1        = op1_q;
        req_o.op2        = op2_q;
        req_o.jump_op1   = jump_op1_q;
        req_o.jump_op2   = jump_op2_q;
        req_o.pred_taken = pred_taken_q;
        req_o.rd         = rd_q;
        req_o.int_assert = int_assert_q;
        req_o.int_addr   = int_addr_q;
    end

endmodule

`default_nettype wire

/* hdl/exu_commit.sv */
// ##############################
// redirect, trap and link output registers
// ##############################
`timescale 1ns/1ps
`default_nettype none

module exu_commit (
    input  wire                                clk_i,
    input  wire                                arst_n_i,
    input  wire exu_pkg::bjp_req_t             req_i,
    input  wire                                jump_flag_i,
    input  wire [exu_pkg::INST_ADDR_WIDTH-1:0] jump_addr_i,
    input  wire                                misaligned_i,
    output exu_pkg::redirect_t                 redirect_o,
    output exu_pkg::trap_t                     trap_o,
    output exu_pkg::link_t                     link_o
);
    import exu_pkg::*;

    logic                       is_jump;     // jal or jalr in the slot
    logic                       redirect_d;
    logic                       trap_d;
    logic                       link_d;

    logic                       squash_q;    // wrong-path slot after redirect/trap
    logic                       redirect_vq;
    logic                       trap_vq;
    logic                       link_vq;
    logic [INST_ADDR_WIDTH-1:0] target_q;    // redirect target and trap tval
    logic [INST_ADDR_WIDTH-1:0] trap_pc_q;
    logic [REG_ADDR_WIDTH-1:0]  link_rd_q;
    logic [XLEN-1:0]            link_data_q;

    assign is_jump = req_i.valid & (req_i.op.jal | req_i.op.jalr);

    assign redirect_d = jump_flag_i & ~squash_q;
    assign trap_d     = misaligned_i & ~squash_q;

    // no link for x0, a trapping jump, or when an interrupt takes the slot
    assign link_d = is_jump
                  & (req_i.rd != '0)
                  & ~misaligned_i
                  & ~req_i.int_assert
                  & ~squash_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            squash_q    <= 1'b0;
            redirect_vq <= 1'b0;
            trap_vq     <= 1'b0;
            link_vq     <= 1'b0;
        end else begin
            squash_q    <= redirect_d | trap_d;  // one slot only
            redirect_vq <= redirect_d;
            trap_vq     <= trap_d;
            link_vq     <= link_d;
        end
    end

    always_ff @(posedge clk_i) begin
        target_q    <= jump_addr_i;
        trap_pc_q   <= req_i.pc;
        link_rd_q   <= req_i.rd;
        link_data_q <= req_i.pc + XLEN'(4);  // return address
    end

    always_comb begin
        redirect_o.valid  = redirect_vq;
        redirect_o.target = target_q;

        trap_o.valid = trap_vq;
        trap_o.pc    = trap_pc_q;
        trap_o.tval  = target_q;

        link_o.valid = link_vq;
        link_o.rd    = link_rd_q;
        link_o.data  = link_data_q;
    end

endmodule

`default_nettype wire

/* hdl/exu_ctrl_top.sv */
// ##############################
// decode, resolution and commit of the bjp path
// ##############################
`timescale 1ns/1ps
`default_nettype none

module exu_ctrl_top (
    input  wire                                clk_i,
    input  wire                                arst_n_i,
    input  wire                                valid_i,
    input  wire [exu_pkg::INST_ADDR_WIDTH-1:0] pc_i,
    input  wire [31:0]                         inst_i,
    input  wire [exu_pkg::XLEN-1:0]            rs1_data_i,
    input  wire [exu_pkg::XLEN-1:0]            rs2_data_i,
    input  wire                                int_assert_i,
    input  wire [exu_pkg::INST_ADDR_WIDTH-1:0] int_addr_i,
    output exu_pkg::redirect_t                 redirect_o,
    output exu_pkg::trap_t                     trap_o,
    output exu_pkg::link_t                     link_o
);
    import exu_pkg::*;

    bjp_req_t                   req;         // decoded slot, 1 cycle after inputs
    logic                       jump_flag;
    logic [INST_ADDR_WIDTH-1:0] jump_addr;
    logic                       misaligned;

    // stage 1, decode register
    bjp_decode u_bjp_decode (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .valid_i      (valid_i),
        .pc_i         (pc_i),
        .inst_i       (inst_i),
        .rs1_data_i   (rs1_data_i),
        .rs2_data_i   (rs2_data_i),
        .int_assert_i (int_assert_i),
        .int_addr_i   (int_addr_i),
        .req_o        (req)
    );

    // resolution, same cycle as req
    exu_bru u_exu_bru (
        .req_i              (req),
        .jump_flag_o        (jump_flag),
        .jump_addr_o        (jump_addr),
        .misaligned_fetch_o (misaligned)
    );

    // stage 2, output register with squash
    exu_commit u_exu_commit (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .req_i        (req),
        .jump_flag_i  (jump_flag),
        .jump_addr_i  (jump_addr),
        .misaligned_i (misaligned),
        .redirect_o   (redirect_o),
        .trap_o       (trap_o),
        .link_o       (link_o)
    );

endmodule

`default_nettype wire
